/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top tb_vga_controller -o sim_tb
	out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* hdl/pixel_pkg.sv */
package pixel_pkg;

	//////////////////////////////////////////////////////////////////////
	// Pixel data
	//////////////////////////////////////////////////////////////////////

	// Red [23:16], green [15:8], blue [7:0]
	typedef logic [23:0] rgb_t;

	//////////////////////////////////////////////////////////////////////
	// FIFO pointers
	//////////////////////////////////////////////////////////////////////

	// Container width for binary and gray pointers
	// FIFO_AW + 1 bits are in use, so FIFO_AW may go up to 7
	localparam int PTR_W = 8;

	typedef logic [PTR_W-1:0] fifo_ptr_t;

	//////////////////////////////////////////////////////////////////////
	// Fill state machine
	//////////////////////////////////////////////////////////////////////

	// FILL doubles as the write strobe and data_req
	typedef enum logic {
		READ = 1'b0,
		FILL = 1'b1
	} fill_state_t;

endpackage

/* hdl/vga_controller.sv */
`timescale 1ns/100ps

module vga_controller import pixel_pkg::*; #(
	parameter int H_VISIBLE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_VISIBLE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	parameter int FIFO_AW = 4
) (
	input logic clk_100mhz_buf,
	input logic vgaclk,
	input logic g_rst,
	input rgb_t wdata,
	output logic data_req,
	output logic blank,
	output logic comp_sync,
	output logic hsync,
	output logic vsync,
	output logic [7:0] pixel_r,
	output logic [7:0] pixel_g,
	output logic [7:0] pixel_b
);

	fill_state_t state;
	fill_state_t next_state;
	rgb_t fifo_dout;
	rgb_t pixel_word;
	logic fifo_full;
	logic fifo_empty;
	logic fifo_rd_en;
	logic pix_rst;

	//////////////////////////////////////////////////////////////////////
	// Fill state machine, 100 MHz domain
	//////////////////////////////////////////////////////////////////////

	// READ waits for room, FILL lasts one cycle
	always_comb begin
		next_state = state;
		case (state)
			READ: begin
				if (!fifo_full) begin
					next_state = FILL;
				end
			end
			FILL: next_state = READ;
			default: next_state = READ;
		endcase
	end

	always_ff @(posedge clk_100mhz_buf) begin
		if (g_rst) begin
			state <= READ;
		end else begin
			state <= next_state;
		end
	end

	// Pull strobe to the source, also the FIFO write enable
	assign data_req = (state == FILL);

	// FIFO head straight to the pins, black outside the visible area
	assign pixel_word = blank ? rgb_t'(0) : fifo_dout;
	assign pixel_r = pixel_word[23:16];
	assign pixel_g = pixel_word[15:8];
	assign pixel_b = pixel_word[7:0];

	//////////////////////////////////////////////////////////////////////
	// Instances
	//////////////////////////////////////////////////////////////////////

	vga_timing #(
		.H_VISIBLE(H_VISIBLE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) i_timing (
		.vgaclk(vgaclk),
		.g_rst(g_rst),
		.empty(fifo_empty),
		.pix_rst(pix_rst),
		.rd_en(fifo_rd_en),
		.blank(blank),
		.hsync(hsync),
		.vsync(vsync),
		.comp_sync(comp_sync)
	);

	xclk_fifo #(
		.FIFO_AW(FIFO_AW)
	) i_fifo (
		.wr_clk(clk_100mhz_buf),
		.g_rst(g_rst),
		.wr_en(data_req),
		.din(wdata),
		.full(fifo_full),
		.rd_clk(vgaclk),
		.pix_rst(pix_rst),
		.rd_en(fifo_rd_en),
		.dout(fifo_dout),
		.empty(fifo_empty)
	);

endmodule

/* hdl/vga_timing.sv */
`timescale 1ns/100ps

module vga_timing import vga_timing_pkg::*; #(
	parameter int H_VISIBLE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_VISIBLE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic vgaclk,
	input logic g_rst,
	input logic empty,
	output logic pix_rst,
	output logic rd_en,
	output logic blank,
	output logic hsync,
	output logic vsync,
	output logic comp_sync
);

	//////////////////////////////////////////////////////////////////////
	// Raster geometry
	//////////////////////////////////////////////////////////////////////

	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	// Counter values for the region edges
	localparam h_count_t H_LAST = h_count_t'(H_TOTAL - 1);
	localparam h_count_t H_VIS_END = h_count_t'(H_VISIBLE);
	localparam h_count_t H_SYNC_ON = h_count_t'(H_VISIBLE + H_FRONT);
	localparam h_count_t H_SYNC_OFF = h_count_t'(H_VISIBLE + H_FRONT + H_SYNC);

	localparam v_count_t V_LAST = v_count_t'(V_TOTAL - 1);
	localparam v_count_t V_VIS_END = v_count_t'(V_VISIBLE);
	localparam v_count_t V_SYNC_ON = v_count_t'(V_VISIBLE + V_FRONT);
	localparam v_count_t V_SYNC_OFF = v_count_t'(V_VISIBLE + V_FRONT + V_SYNC);

	logic [1:0] rst_sync;
	logic started;
	h_count_t h_cnt;
	v_count_t v_cnt;
	logic h_vis;
	logic v_vis;
	logic h_act;
	logic v_act;

	// Reset into the pixel domain, two flops
	always_ff @(posedge vgaclk) begin
		rst_sync <= {rst_sync[0], g_rst};
	end

	assign pix_rst = rst_sync[1];

	// Hold off the raster until the first word shows up
	// Never cleared again until the next reset
	always_ff @(posedge vgaclk) begin
		if (pix_rst) begin
			started <= 1'b0;
		end else if (!empty) begin
			started <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////////////////////////

	// Pixel counter wraps per line, line counter per frame
	always_ff @(posedge vgaclk) begin
		if (pix_rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (started) begin
			if (h_cnt == H_LAST) begin
				h_cnt <= '0;
				if (v_cnt == V_LAST) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// Region decode on the current count
	assign h_vis = (h_cnt < H_VIS_END);
	assign v_vis = (v_cnt < V_VIS_END);
	// Sync windows, both idle before the start
	assign h_act = started && (h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF);
	assign v_act = started && (v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF);

	//////////////////////////////////////////////////////////////////////
	// Registered outputs, one cycle behind the counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge vgaclk) begin
		if (pix_rst) begin
			blank <= 1'b1;
			hsync <= SYNC_INACTIVE;
			vsync <= SYNC_INACTIVE;
			comp_sync <= SYNC_INACTIVE;
		end else begin
			blank <= !(started && h_vis && v_vis);
			hsync <= h_act ? SYNC_ACTIVE : SYNC_INACTIVE;
			vsync <= v_act ? SYNC_ACTIVE : SYNC_INACTIVE;
			// Composite is active when only one of the two pulses is
			comp_sync <= (h_act ^ v_act) ? SYNC_ACTIVE : SYNC_INACTIVE;
		end
	end

	// Pop one word per visible pixel
	assign rd_en = ~blank;

endmodule

/* hdl/vga_timing_pkg.sv */
package vga_timing_pkg;

	//////////////////////////////////////////////////////////////////////
	// Raster counter widths
	//////////////////////////////////////////////////////////////////////

	// Horizontal counter covers up to 2047 pixels per line
	localparam int H_COUNT_W = 11;

	// Vertical counter covers up to 1023 lines per frame
	localparam int V_COUNT_W = 10;

	// Pixel position within a line, visible area first
	typedef logic [H_COUNT_W-1:0] h_count_t;

	// Line position within a frame, visible area first
	typedef logic [V_COUNT_W-1:0] v_count_t;

	//////////////////////////////////////////////////////////////////////
	// Sync polarity
	//////////////////////////////////////////////////////////////////////

	// Negative sync pulses, as for the 640x480 mode
	localparam logic SYNC_ACTIVE = 1'b0;

	// Idle level between pulses and before the raster starts
	localparam logic SYNC_INACTIVE = ~SYNC_ACTIVE;

endpackage

/* hdl/xclk_fifo.sv */
`timescale 1ns/100ps

module xclk_fifo import pixel_pkg::*; #(
	parameter int FIFO_AW = 4
) (
	// Write side, 100 MHz domain
	input logic wr_clk,
	input logic g_rst,
	input logic wr_en,
	input rgb_t din,
	output logic full,
	// Read side, pixel domain
	input logic rd_clk,
	input logic pix_rst,
	input logic rd_en,
	output rgb_t dout,
	output logic empty
);

	localparam int DEPTH = 1 << FIFO_AW;

	// Pointers run over FIFO_AW + 1 bits, the rest of the container stays zero
	localparam fifo_ptr_t PTR_MASK = fifo_ptr_t'((1 << (FIFO_AW + 1)) - 1);

	// Full when the two top gray bits differ and the rest match
	localparam fifo_ptr_t FULL_FLIP = fifo_ptr_t'(3 << (FIFO_AW - 1));

	rgb_t mem [DEPTH];

	fifo_ptr_t wr_bin;
	fifo_ptr_t wr_gray;
	fifo_ptr_t wr_bin_next;
	fifo_ptr_t wr_gray_next;
	fifo_ptr_t rq1_gray;
	fifo_ptr_t rq2_gray;
	logic wr_ok;

	fifo_ptr_t rd_bin;
	fifo_ptr_t rd_gray;
	fifo_ptr_t rd_bin_next;
	fifo_ptr_t rd_gray_next;
	fifo_ptr_t wq1_gray;
	fifo_ptr_t wq2_gray;
	logic rd_ok;

	function automatic fifo_ptr_t bin_to_gray(input fifo_ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Write domain
	//////////////////////////////////////////////////////////////////////

	// Writes into a full FIFO are dropped
	assign wr_ok = wr_en && !full;
	assign wr_bin_next = (wr_bin + fifo_ptr_t'(wr_ok)) & PTR_MASK;
	assign wr_gray_next = bin_to_gray(wr_bin_next);

	// Storage, written on the edge that ends the FILL cycle
	always_ff @(posedge wr_clk) begin
		if (wr_ok) begin
			mem[wr_bin[FIFO_AW-1:0]] <= din;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (g_rst) begin
			wr_bin <= '0;
			wr_gray <= '0;
			full <= 1'b0;
		end else begin
			wr_bin <= wr_bin_next;
			wr_gray <= wr_gray_next;
			// Compared against a stale read pointer, so full may linger
			full <= (wr_gray_next == (rq2_gray ^ FULL_FLIP));
		end
	end

	// Read pointer into the write domain
	always_ff @(posedge wr_clk) begin
		if (g_rst) begin
			rq1_gray <= '0;
			rq2_gray <= '0;
		end else begin
			rq1_gray <= rd_gray;
			rq2_gray <= rq1_gray;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read domain
	//////////////////////////////////////////////////////////////////////

	// Reads from an empty FIFO are dropped
	assign rd_ok = rd_en && !empty;
	assign rd_bin_next = (rd_bin + fifo_ptr_t'(rd_ok)) & PTR_MASK;
	assign rd_gray_next = bin_to_gray(rd_bin_next);

	always_ff @(posedge rd_clk) begin
		if (pix_rst) begin
			rd_bin <= '0;
			rd_gray <= '0;
			empty <= 1'b1;
		end else begin
			rd_bin <= rd_bin_next;
			rd_gray <= rd_gray_next;
			// Stale write pointer, so empty may linger a cycle or two
			empty <= (rd_gray_next == wq2_gray);
		end
	end

	// Write pointer into the read domain
	always_ff @(posedge rd_clk) begin
		if (pix_rst) begin
			wq1_gray <= '0;
			wq2_gray <= '0;
		end else begin
			wq1_gray <= wr_gray;
			wq2_gray <= wq1_gray;
		end
	end

	// First word fall through
	// Head word is valid whenever empty is low
	assign dout = mem[rd_bin[FIFO_AW-1:0]];

endmodule

/* tb/tb_vga_controller.sv */
`timescale 1ns/100ps

module tb_vga_controller import pixel_pkg::*; ();

	//////////////////////////////////////////////////////////////////////
	// Reduced raster for simulation
	//////////////////////////////////////////////////////////////////////

	localparam int H_VISIBLE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 2;
	localparam int V_VISIBLE = 8;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int FIFO_AW = 4;

	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAMES = 4;
	// Planned frames plus one for start-up, 40 ns pixel period
	localparam int WATCHDOG_NS = (FRAMES + 1) * V_TOTAL * H_TOTAL * 40;

	logic clk_100mhz_buf;
	logic vgaclk;
	logic g_rst;
	rgb_t wdata;
	logic data_req;
	logic blank;
	logic comp_sync;
	logic hsync;
	logic vsync;
	logic [7:0] pixel_r;
	logic [7:0] pixel_g;
	logic [7:0] pixel_b;
	int seed;
	int timeout_errs;

	// 100 MHz write clock
	initial begin
		clk_100mhz_buf = 1'b0;
		forever #5 clk_100mhz_buf = ~clk_100mhz_buf;
	end

	// 25 MHz pixel clock
	initial begin
		vgaclk = 1'b0;
		forever #20 vgaclk = ~vgaclk;
	end

	vga_controller #(
		.H_VISIBLE(H_VISIBLE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK),
		.FIFO_AW(FIFO_AW)
	) i_dut (
		.clk_100mhz_buf(clk_100mhz_buf),
		.vgaclk(vgaclk),
		.g_rst(g_rst),
		.wdata(wdata),
		.data_req(data_req),
		.blank(blank),
		.comp_sync(comp_sync),
		.hsync(hsync),
		.vsync(vsync),
		.pixel_r(pixel_r),
		.pixel_g(pixel_g),
		.pixel_b(pixel_b)
	);

	vga_monitor #(
		.H_VISIBLE(H_VISIBLE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK),
		.FIFO_AW(FIFO_AW)
	) i_mon (
		.clk_100mhz_buf(clk_100mhz_buf),
		.vgaclk(vgaclk),
		.g_rst(g_rst),
		.data_req(data_req),
		.wdata(wdata),
		.blank(blank),
		.hsync(hsync),
		.vsync(vsync),
		.comp_sync(comp_sync),
		.pixel_r(pixel_r),
		.pixel_g(pixel_g),
		.pixel_b(pixel_b)
	);

	bind vga_controller vga_controller_sva i_sva (
		.clk_100mhz_buf(clk_100mhz_buf),
		.vgaclk(vgaclk),
		.g_rst(g_rst),
		.data_req(data_req),
		.blank(blank),
		.hsync(hsync),
		.vsync(vsync),
		.comp_sync(comp_sync),
		.pixel_r(pixel_r),
		.pixel_g(pixel_g),
		.pixel_b(pixel_b)
	);

	// Closing count line and verdict
	task automatic finish_run();
		int other_total;
		other_total = i_mon.other_cnt + timeout_errs;
		$display("mismatches: %0d, other errors: %0d", i_mon.mismatch_cnt, other_total);
		if (i_mon.mismatch_cnt == 0 && other_total == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reset and source stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h4066_3873;
		timeout_errs = 0;
		g_rst = 1'b1;
		wdata = rgb_t'($random(seed));
		repeat (3) @(posedge clk_100mhz_buf);
		g_rst <= 1'b0;
		// Fresh word after each write edge
		forever begin
			@(posedge clk_100mhz_buf);
			if (!g_rst && data_req) begin
				wdata <= rgb_t'($random(seed));
			end
		end
	end

	// Normal end after the planned frames, first vsync fall is the alignment
	initial begin
		wait (i_mon.frame_cnt >= FRAMES + 1);
		finish_run();
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the raster never completed the planned frames");
		timeout_errs = timeout_errs + 1;
		finish_run();
	end

endmodule

/* tb/vga_controller_sva.sv */
`timescale 1ns/100ps

module vga_controller_sva import vga_timing_pkg::*; (
	input logic clk_100mhz_buf,
	input logic vgaclk,
	input logic g_rst,
	input logic data_req,
	input logic blank,
	input logic hsync,
	input logic vsync,
	input logic comp_sync,
	input logic [7:0] pixel_r,
	input logic [7:0] pixel_g,
	input logic [7:0] pixel_b
);

	// One-cycle pull strobe
	a_req_single: assert property (@(posedge clk_100mhz_buf) disable iff (g_rst)
		data_req |=> !data_req)
		else $error("data_req high on two consecutive cycles");

	// Composite sync from the two pulses
	a_comp_xor: assert property (@(posedge vgaclk) disable iff (g_rst)
		!$isunknown({hsync, vsync}) |->
		comp_sync == (((hsync == SYNC_ACTIVE) ^ (vsync == SYNC_ACTIVE)) ?
			SYNC_ACTIVE : SYNC_INACTIVE))
		else $error("comp_sync does not follow hsync and vsync");

	// Black outside the visible area
	a_blank_black: assert property (@(posedge vgaclk) disable iff (g_rst)
		blank === 1'b1 |-> {pixel_r, pixel_g, pixel_b} == 24'h0)
		else $error("pixel outputs nonzero while blanked");

endmodule

/* tb/vga_monitor.sv */
`timescale 1ns/100ps

module vga_monitor import pixel_pkg::*; import vga_timing_pkg::*; #(
	parameter int H_VISIBLE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_VISIBLE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	parameter int FIFO_AW = 4
) (
	input logic clk_100mhz_buf,
	input logic vgaclk,
	input logic g_rst,
	input logic data_req,
	input rgb_t wdata,
	input logic blank,
	input logic hsync,
	input logic vsync,
	input logic comp_sync,
	input logic [7:0] pixel_r,
	input logic [7:0] pixel_g,
	input logic [7:0] pixel_b
);

	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	int mismatch_cnt = 0;
	int other_cnt = 0;
	int frame_cnt = 0;
	rgb_t ref_q[$];
	logic req_checked = 1'b0;
	logic [1:0] rst_pipe = 2'b00;
	logic pix_ready = 1'b0;
	logic raster_seen = 1'b0;
	logic aligned = 1'b0;
	logic vsync_q = 1'b1;
	h_count_t m_h;
	v_count_t m_v;

	task automatic note_mismatch(input string msg);
		mismatch_cnt = mismatch_cnt + 1;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	task automatic note_failure(input string msg);
		other_cnt = other_cnt + 1;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Write side sampled mid-cycle while the word is held
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_100mhz_buf) begin
		if (!g_rst) begin
			// First cycle after reset must not request
			if (!req_checked) begin
				req_checked = 1'b1;
				if (data_req !== 1'b0) begin
					note_mismatch($sformatf("data_req %b after reset, expected 0", data_req));
				end
			end
			if (data_req === 1'b1) begin
				ref_q.push_back(wdata);
				// FIFO depth plus the word in the crossing
				if (ref_q.size() > (1 << FIFO_AW) + 1) begin
					note_failure("more words written than the FIFO can hold");
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pixel side raster model
	//////////////////////////////////////////////////////////////////////

	// g_rst reaches the pixel domain through two flops
	// Outputs hold their idle values from the edge that samples it
	always @(posedge vgaclk) begin
		if (rst_pipe[1]) begin
			pix_ready <= 1'b1;
		end
		rst_pipe <= {rst_pipe[0], g_rst};
	end

	always @(negedge vgaclk) begin
		logic exp_blank;
		logic h_act;
		logic v_act;
		rgb_t got;
		rgb_t exp_word;
		if (pix_ready) begin
			got = {pixel_r, pixel_g, pixel_b};
			// Idle outputs until the first visible pixel
			if (!raster_seen) begin
				if (blank === 1'b0) begin
					raster_seen = 1'b1;
				end else if ({hsync, vsync, comp_sync} !== {3{SYNC_INACTIVE}} || got !== '0) begin
					note_mismatch($sformatf("idle outputs h%b v%b c%b pix %h",
						hsync, vsync, comp_sync, got));
				end
			end
			if (raster_seen) begin
				// Advance the model or lock onto the first vsync fall
				if (aligned) begin
					if (m_h == h_count_t'(H_TOTAL - 1)) begin
						m_h = '0;
						m_v = (m_v == v_count_t'(V_TOTAL - 1)) ? '0 : m_v + 1'b1;
					end else begin
						m_h = m_h + 1'b1;
					end
				end else if (vsync_q == SYNC_INACTIVE && vsync == SYNC_ACTIVE) begin
					aligned = 1'b1;
					m_h = '0;
					m_v = v_count_t'(V_VISIBLE + V_FRONT);
				end
				if (aligned) begin
					h_act = (m_h >= h_count_t'(H_VISIBLE + H_FRONT))
						&& (m_h < h_count_t'(H_VISIBLE + H_FRONT + H_SYNC));
					v_act = (m_v >= v_count_t'(V_VISIBLE + V_FRONT))
						&& (m_v < v_count_t'(V_VISIBLE + V_FRONT + V_SYNC));
					exp_blank = !((m_h < h_count_t'(H_VISIBLE))
						&& (m_v < v_count_t'(V_VISIBLE)));
					if (m_h == '0 && m_v == v_count_t'(V_VISIBLE + V_FRONT)) begin
						frame_cnt = frame_cnt + 1;
					end
					if (blank !== exp_blank) begin
						note_mismatch($sformatf("blank %b, expected %b at h%0d v%0d",
							blank, exp_blank, m_h, m_v));
					end
					if (hsync !== (h_act ? SYNC_ACTIVE : SYNC_INACTIVE)
						|| vsync !== (v_act ? SYNC_ACTIVE : SYNC_INACTIVE)
						|| comp_sync !== ((h_act ^ v_act) ? SYNC_ACTIVE : SYNC_INACTIVE)) begin
						note_mismatch($sformatf("sync h%b v%b c%b wrong at h%0d v%0d",
							hsync, vsync, comp_sync, m_h, m_v));
					end
				end
				// Pixel data against the written stream
				if (blank === 1'b0) begin
					if (ref_q.size() == 0) begin
						note_failure("visible pixel shown with no word written");
					end else begin
						exp_word = ref_q.pop_front();
						if (got !== exp_word) begin
							note_mismatch($sformatf("pixel %h, expected %h", got, exp_word));
						end
					end
				end else if (got !== '0) begin
					note_mismatch($sformatf("pixel %h while blanked, expected 0", got));
				end
			end
			vsync_q = vsync;
		end
	end

endmodule

/* vlog.f */
hdl/vga_timing_pkg.sv
hdl/pixel_pkg.sv
hdl/vga_timing.sv
hdl/xclk_fifo.sv
hdl/vga_controller.sv
tb/vga_monitor.sv
tb/vga_controller_sva.sv
tb/tb_vga_controller.sv
